// File: hw/app_beat_ram.sv
/*
 * on-chip beat memory with an app-style command interface
 * one command per cycle, write needs app_en and app_wdf_wren together
 * read data returns RD_LATENCY cycles after the command, in order
 * no commands are taken until calibration completes
 */
`timescale 1ns/10ps

module app_beat_ram (
	input  logic               ti_clk,
	input  logic               rst_n,
	input  logic               app_en,
	input  logic               app_cmd_wr,
	input  ramtest_pkg::addr_t app_addr,
	input  logic               app_wdf_wren,
	input  ramtest_pkg::beat_t app_wdf_data,
	output logic               app_rdy,
	output logic               app_wdf_rdy,
	output ramtest_pkg::beat_t app_rd_data,
	output logic               app_rd_data_valid,
	output logic               calib_done
);

	ramtest_pkg::beat_t                  mem [ramtest_pkg::MEM_DEPTH];
	ramtest_pkg::beat_t                  data_pipe [ramtest_pkg::RD_LATENCY];
	logic [ramtest_pkg::RD_LATENCY-1:0]  vld_pipe;
	logic [ramtest_pkg::CALIB_CNT_W-1:0] cal_cnt;
	logic                                wr_take;
	logic                                rd_take;

	// ------------------------------------------------------------
	// calibration delay
	always_ff @(posedge ti_clk or negedge rst_n) begin
		if (!rst_n) begin
			cal_cnt    <= '0;
			calib_done <= 1'b0;
		end else if (!calib_done) begin
			cal_cnt <= cal_cnt + 1'b1;
			if (cal_cnt == ramtest_pkg::CALIB_CNT_W'(ramtest_pkg::CALIB_CYCLES - 1))
				calib_done <= 1'b1;
		end
	end

	assign app_rdy     = calib_done;
	assign app_wdf_rdy = calib_done;
	assign wr_take     = app_en && app_cmd_wr && app_wdf_wren && app_rdy && app_wdf_rdy;
	assign rd_take     = app_en && !app_cmd_wr && app_rdy;

	// array and read data stages, no reset
	always_ff @(posedge ti_clk) begin
		if (wr_take)
			mem[app_addr] <= app_wdf_data; // visible the next cycle
		if (rd_take)
			data_pipe[0] <= mem[app_addr];
		for (int i = 1; i < ramtest_pkg::RD_LATENCY; i++)
			data_pipe[i] <= data_pipe[i-1];
	end

	always_ff @(posedge ti_clk or negedge rst_n) begin
		if (!rst_n) begin
			vld_pipe <= '0;
		end else begin
			vld_pipe[0] <= rd_take;
			for (int i = 1; i < ramtest_pkg::RD_LATENCY; i++)
				vld_pipe[i] <= vld_pipe[i-1];
		end
	end

	assign app_rd_data       = data_pipe[ramtest_pkg::RD_LATENCY-1];
	assign app_rd_data_valid = vld_pipe[ramtest_pkg::RD_LATENCY-1];

endmodule

// File: hw/beat_fifo.sv
/*
 * synchronous show-ahead FIFO, FIFO_DEPTH entries of item_t
 * rd_data is the head entry, valid whenever empty is low
 * writes while full and reads while empty are ignored
 * clr has priority over a write or read in the same cycle
 */
`timescale 1ns/10ps

module beat_fifo #(
	parameter type item_t = ramtest_pkg::beat_t
) (
	input  logic                               ti_clk,
	input  logic                               rst_n,
	input  logic                               clr,
	input  logic                               wr,
	input  item_t                              wr_data,
	input  logic                               rd,
	output item_t                              rd_data,
	output logic                               empty,
	output logic                               full,
	output logic [ramtest_pkg::FIFO_CNT_W-1:0] count
);

	item_t                               mem [ramtest_pkg::FIFO_DEPTH]; // storage, no reset
	logic [ramtest_pkg::FIFO_PTR_W-1:0]  wr_ptr;
	logic [ramtest_pkg::FIFO_PTR_W-1:0]  rd_ptr;
	logic                                do_wr;
	logic                                do_rd;

	assign empty   = (count == '0);
	assign full    = (count == ramtest_pkg::FIFO_CNT_W'(ramtest_pkg::FIFO_DEPTH));
	assign do_wr   = wr && !full;
	assign do_rd   = rd && !empty;
	assign rd_data = mem[rd_ptr]; // show-ahead

	always_ff @(posedge ti_clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	// ------------------------------------------------------------
	// pointers and fill count
	always_ff @(posedge ti_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (clr) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == ramtest_pkg::FIFO_PTR_W'(ramtest_pkg::FIFO_DEPTH - 1)) ?
					'0 : wr_ptr + 1'b1; // wrap for any depth
			if (do_rd)
				rd_ptr <= (rd_ptr == ramtest_pkg::FIFO_PTR_W'(ramtest_pkg::FIFO_DEPTH - 1)) ?
					'0 : rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

endmodule

// File: hw/ram_traffic_ctrl.sv
/*
 * moves beats from the in fifo to memory and back to the out fifo
 * memory is used as a ring, reads return beats in write order
 * reads are issued only while the out fifo has room for every beat in flight
 * reads still in flight at a soft reset are discarded when they return
 */
`timescale 1ns/10ps

module ram_traffic_ctrl (
	input  logic                               ti_clk,
	input  logic                               rst_n,
	input  logic                               clr,
	input  logic                               rd_en,
	input  logic                               wr_en,
	input  ramtest_pkg::beat_t                 ib_data,
	input  logic                               ib_empty,
	input  logic                               app_rdy,
	input  logic                               app_wdf_rdy,
	input  ramtest_pkg::beat_t                 app_rd_data,
	input  logic                               app_rd_data_valid,
	input  logic [ramtest_pkg::FIFO_CNT_W-1:0] ob_count,
	output logic                               ib_rd,
	output logic                               app_en,
	output logic                               app_cmd_wr,
	output ramtest_pkg::addr_t                 app_addr,
	output logic                               app_wdf_wren,
	output ramtest_pkg::beat_t                 app_wdf_data,
	output logic                               ob_wr,
	output ramtest_pkg::beat_t                 ob_data
);

	ramtest_pkg::addr_t                  wr_ptr;
	ramtest_pkg::addr_t                  rd_ptr;
	logic [ramtest_pkg::MEM_CNT_W-1:0]   stored;   // beats in memory, not yet read
	logic [ramtest_pkg::FIFO_CNT_W-1:0]  inflight; // reads issued, data not back
	logic [ramtest_pkg::FIFO_CNT_W-1:0]  drop;     // stale reads from before clr
	logic [ramtest_pkg::FIFO_CNT_W:0]    ob_need;
	logic                                mem_full;
	logic                                ob_room;
	logic                                wr_go;
	logic                                rd_go;
	logic                                rd_back;

	// ------------------------------------------------------------
	// issue decision, write wins
	assign mem_full = (stored == ramtest_pkg::MEM_CNT_W'(ramtest_pkg::MEM_DEPTH));
	assign ob_need  = {1'b0, ob_count} + {1'b0, inflight};
	assign ob_room  = (ob_need < (ramtest_pkg::FIFO_CNT_W+1)'(ramtest_pkg::FIFO_DEPTH));
	assign wr_go    = !clr && wr_en && !ib_empty && !mem_full && app_rdy && app_wdf_rdy;
	assign rd_go    = !clr && rd_en && (stored != '0) && ob_room && app_rdy && !wr_go;

	assign app_en       = wr_go || rd_go;
	assign app_cmd_wr   = wr_go;
	assign app_wdf_wren = wr_go;                  // data goes with the command
	assign app_wdf_data = ib_data;
	assign app_addr     = wr_go ? wr_ptr : rd_ptr;
	assign ib_rd        = wr_go;                  // pop with the memory write

	// returned beats go straight to the out fifo
	assign rd_back = app_rd_data_valid && (drop == '0);
	assign ob_wr   = rd_back;
	assign ob_data = app_rd_data;

	always_ff @(posedge ti_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			stored   <= '0;
			inflight <= '0;
			drop     <= '0;
		end else if (clr) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			stored   <= '0;
			inflight <= '0;
			drop     <= drop + inflight - (app_rd_data_valid ? 1'b1 : 1'b0); // still owed
		end else begin
			if (wr_go) begin
				wr_ptr <= wr_ptr + 1'b1; // ring wraps at MEM_DEPTH
				stored <= stored + 1'b1;
			end else if (rd_go) begin
				rd_ptr <= rd_ptr + 1'b1;
				stored <= stored - 1'b1;
			end
			if (rd_go && !rd_back)
				inflight <= inflight + 1'b1;
			else if (rd_back && !rd_go)
				inflight <= inflight - 1'b1;
			if (app_rd_data_valid && drop != '0)
				drop <= drop - 1'b1; // discard stale beat
		end
	end

endmodule

// File: hw/ramtest_ctrl_regs.sv
/*
 * control register, loaded whole on each ctrl_write strobe
 * soft reset bit becomes a one-cycle pulse, it is not held
 * status is registered, so it lags the live levels by one cycle
 */
`timescale 1ns/10ps

module ramtest_ctrl_regs (
	input  logic                                ti_clk,
	input  logic                                rst_n,
	input  logic                                ctrl_write,
	input  logic [ramtest_pkg::CTRL_W-1:0]      ctrl_data,
	input  logic                                calib_done,
	input  logic                                pi_full,
	input  logic                                po_empty,
	output logic                                rd_en,
	output logic                                wr_en,
	output logic                                soft_rst,
	output logic [ramtest_pkg::STATUS_W-1:0]    status
);

	// enables and soft reset pulse
	always_ff @(posedge ti_clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_en    <= 1'b0;
			wr_en    <= 1'b0;
			soft_rst <= 1'b0;
		end else if (ctrl_write) begin
			rd_en    <= ctrl_data[ramtest_pkg::CTRL_RD_EN];
			wr_en    <= ctrl_data[ramtest_pkg::CTRL_WR_EN];
			soft_rst <= ctrl_data[ramtest_pkg::CTRL_SOFT_RST];
		end else begin
			soft_rst <= 1'b0; // self clearing
		end
	end

	// status gather, stands in for the led outputs
	always_ff @(posedge ti_clk or negedge rst_n) begin
		if (!rst_n) begin
			status                             <= '0;
			status[ramtest_pkg::STAT_PO_EMPTY] <= 1'b1; // out fifo empty at reset
		end else begin
			status[ramtest_pkg::STAT_CALIB]    <= calib_done;
			status[ramtest_pkg::STAT_PI_FULL]  <= pi_full;
			status[ramtest_pkg::STAT_PO_EMPTY] <= po_empty;
			status[ramtest_pkg::STAT_RD_EN]    <= rd_en;
			status[ramtest_pkg::STAT_WR_EN]    <= wr_en;
		end
	end

endmodule

// File: hw/ramtest_pkg.sv
/*
 * shared types and sizing for the ram loopback subsystem
 * FIFO_DEPTH and MEM_DEPTH are assumed to be at least 2
 * status and control bit positions follow the wire-in layout
 */
package ramtest_pkg;

	// ------------------------------------------------------------
	// sizing
	localparam int WORD_W         = 16;
	localparam int WORDS_PER_BEAT = 8;
	localparam int BEAT_W         = WORD_W * WORDS_PER_BEAT; // 128
	localparam int WIDX_W         = $clog2(WORDS_PER_BEAT);  // word index in a beat
	localparam int MEM_DEPTH      = 16;                      // beats
	localparam int ADDR_W         = $clog2(MEM_DEPTH);
	localparam int MEM_CNT_W      = $clog2(MEM_DEPTH + 1);   // 0..MEM_DEPTH
	localparam int FIFO_DEPTH     = 4;                       // beats per fifo
	localparam int FIFO_PTR_W     = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W     = $clog2(FIFO_DEPTH + 1);
	localparam int RD_LATENCY     = 2;                       // cmd to rd_data_valid
	localparam int CALIB_CYCLES   = 20;
	localparam int CALIB_CNT_W    = $clog2(CALIB_CYCLES + 1);

	// ------------------------------------------------------------
	// control and status bits
	localparam int CTRL_W         = 3;
	localparam int CTRL_RD_EN     = 0;
	localparam int CTRL_WR_EN     = 1;
	localparam int CTRL_SOFT_RST  = 2;
	localparam int STATUS_W       = 5;
	localparam int STAT_CALIB     = 0;
	localparam int STAT_PI_FULL   = 1;
	localparam int STAT_PO_EMPTY  = 2;
	localparam int STAT_RD_EN     = 3;
	localparam int STAT_WR_EN     = 4;

	typedef logic [WORD_W-1:0] word_t; // one pipe word
	typedef logic [BEAT_W-1:0] beat_t; // word 0 in the low bits
	typedef logic [ADDR_W-1:0] addr_t; // beat address

endpackage

// File: hw/ramtest_top.sv
/*
 * host to memory loopback, single clock ti_clk
 * host checks pi_full before pi_write, words offered while full are lost
 * po_data is valid while po_empty is low, po_read takes it
 * soft reset leaves memory contents and calibration alone
 */
`timescale 1ns/10ps

module ramtest_top (
	input  logic                             ti_clk,
	input  logic                             rst_n,
	input  logic                             pi_write,
	input  ramtest_pkg::word_t               pi_data,
	input  logic                             po_read,
	input  logic                             ctrl_write,
	input  logic [ramtest_pkg::CTRL_W-1:0]   ctrl_data,
	output logic                             pi_full,
	output ramtest_pkg::word_t               po_data,
	output logic                             po_empty,
	output logic [ramtest_pkg::STATUS_W-1:0] status
);

	logic                               rd_en, wr_en, soft_rst, calib_done;
	logic                               pk_wr, ib_rd, ib_empty, ib_full;
	logic                               ob_wr, ob_rd, ob_empty;
	logic [ramtest_pkg::FIFO_CNT_W-1:0] ob_count;
	ramtest_pkg::beat_t                 pk_data, ib_data, ob_wdata, ob_rdata;
	// memory app interface
	logic                               app_en, app_cmd_wr, app_wdf_wren;
	logic                               app_rdy, app_wdf_rdy, app_rd_data_valid;
	ramtest_pkg::addr_t                 app_addr;
	ramtest_pkg::beat_t                 app_wdf_data, app_rd_data;

	ramtest_ctrl_regs u_ctrl_regs (
		.ti_clk, .rst_n, .ctrl_write, .ctrl_data, .calib_done, .pi_full, .po_empty,
		.rd_en, .wr_en, .soft_rst, .status);

	// ------------------------------------------------------------
	// write path
	word_packer u_packer (
		.ti_clk, .rst_n, .clr(soft_rst), .pi_write, .pi_data, .fifo_full(ib_full),
		.beat_wr(pk_wr), .beat_data(pk_data), .pi_full);

	beat_fifo #(.item_t(ramtest_pkg::beat_t)) u_ib_fifo (
		.ti_clk, .rst_n, .clr(soft_rst), .wr(pk_wr), .wr_data(pk_data), .rd(ib_rd),
		.rd_data(ib_data), .empty(ib_empty), .full(ib_full), .count());

	ram_traffic_ctrl u_traffic (
		.ti_clk, .rst_n, .clr(soft_rst), .rd_en, .wr_en, .ib_data, .ib_empty,
		.app_rdy, .app_wdf_rdy, .app_rd_data, .app_rd_data_valid, .ob_count,
		.ib_rd, .app_en, .app_cmd_wr, .app_addr, .app_wdf_wren, .app_wdf_data,
		.ob_wr, .ob_data(ob_wdata));

	app_beat_ram u_mem (
		.ti_clk, .rst_n, .app_en, .app_cmd_wr, .app_addr, .app_wdf_wren, .app_wdf_data,
		.app_rdy, .app_wdf_rdy, .app_rd_data, .app_rd_data_valid, .calib_done);

	// ------------------------------------------------------------
	// read path, room is checked by the traffic controller
	beat_fifo #(.item_t(ramtest_pkg::beat_t)) u_ob_fifo (
		.ti_clk, .rst_n, .clr(soft_rst), .wr(ob_wr), .wr_data(ob_wdata), .rd(ob_rd),
		.rd_data(ob_rdata), .empty(ob_empty), .full(), .count(ob_count));

	word_unpacker u_unpacker (
		.ti_clk, .rst_n, .clr(soft_rst), .beat_data(ob_rdata), .fifo_empty(ob_empty),
		.po_read, .po_data, .po_empty, .beat_rd(ob_rd));

endmodule

// File: hw/word_packer.sv
/*
 * packs eight host words into one beat, word 0 in the low bits
 * the full beat is written to the fifo the cycle after word 7
 * host must watch pi_full; a word offered while it is high is dropped
 */
`timescale 1ns/10ps

module word_packer (
	input  logic               ti_clk,
	input  logic               rst_n,
	input  logic               clr,
	input  logic               pi_write,
	input  ramtest_pkg::word_t pi_data,
	input  logic               fifo_full,
	output logic               beat_wr,
	output ramtest_pkg::beat_t beat_data,
	output logic               pi_full
);

	logic [ramtest_pkg::WIDX_W-1:0] idx;      // next word slot
	logic                           beat_pend; // complete beat not yet in fifo
	logic                           take;
	logic                           last_slot;

	assign last_slot = (idx == ramtest_pkg::WIDX_W'(ramtest_pkg::WORDS_PER_BEAT - 1));
	assign pi_full   = fifo_full && (beat_pend || last_slot); // stall host
	assign take      = pi_write && !pi_full;
	assign beat_wr   = beat_pend && !fifo_full;

	// payload, no reset
	always_ff @(posedge ti_clk) begin
		if (take)
			beat_data[idx*ramtest_pkg::WORD_W +: ramtest_pkg::WORD_W] <= pi_data;
	end

	always_ff @(posedge ti_clk or negedge rst_n) begin
		if (!rst_n) begin
			idx       <= '0;
			beat_pend <= 1'b0;
		end else if (clr) begin
			idx       <= '0;
			beat_pend <= 1'b0;
		end else begin
			if (take)
				idx <= last_slot ? '0 : idx + 1'b1;
			if (take && last_slot)
				beat_pend <= 1'b1; // beat complete
			else if (beat_wr)
				beat_pend <= 1'b0;
		end
	end

endmodule

// File: hw/word_unpacker.sv
/*
 * presents the head beat of the out fifo as eight words
 * po_data is valid while po_empty is low, po_read advances
 * the beat is popped when word 7 is read
 */
`timescale 1ns/10ps

module word_unpacker (
	input  logic               ti_clk,
	input  logic               rst_n,
	input  logic               clr,
	input  ramtest_pkg::beat_t beat_data,
	input  logic               fifo_empty,
	input  logic               po_read,
	output ramtest_pkg::word_t po_data,
	output logic               po_empty,
	output logic               beat_rd
);

	logic [ramtest_pkg::WIDX_W-1:0] idx; // word shown to host
	logic                           adv;
	logic                           last_slot;

	assign po_empty  = fifo_empty;
	assign adv       = po_read && !fifo_empty; // read while empty ignored
	assign last_slot = (idx == ramtest_pkg::WIDX_W'(ramtest_pkg::WORDS_PER_BEAT - 1));
	assign beat_rd   = adv && last_slot;
	assign po_data   = beat_data[idx*ramtest_pkg::WORD_W +: ramtest_pkg::WORD_W];

	always_ff @(posedge ti_clk or negedge rst_n) begin
		if (!rst_n) begin
			idx <= '0;
		end else if (clr) begin
			idx <= '0;
		end else if (adv) begin
			idx <= last_slot ? '0 : idx + 1'b1; // next beat starts at word 0
		end
	end

endmodule

// File: project.f
hw/ramtest_pkg.sv
hw/ramtest_ctrl_regs.sv
hw/beat_fifo.sv
hw/word_packer.sv
hw/word_unpacker.sv
hw/app_beat_ram.sv
hw/ram_traffic_ctrl.sv
hw/ramtest_top.sv
verification/ramtest_assert.sv
verification/ramtest_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ram loopback testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -Mdir obj_dir \
	--top-module ramtest_tb -f project.f -o ramtest_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/ramtest_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: verification/ramtest_assert.sv
/*
 * handshake checks on the traffic controller memory port
 * bound into ram_traffic_ctrl; app_rdy follows calib_done there
 */
`timescale 1ns/10ps

module ramtest_assert (
	input logic ti_clk,
	input logic rst_n,
	input logic app_en,
	input logic app_cmd_wr,
	input logic app_wdf_wren,
	input logic app_rdy,
	input logic app_wdf_rdy,
	input logic app_rd_data_valid,
	input logic ob_wr
);

	// write needs data strobe and data path ready
	a_wr_rdy: assert property (@(posedge ti_clk) disable iff (!rst_n)
		app_en && app_cmd_wr |-> app_wdf_wren && app_wdf_rdy)
		else $error("write command issued while app_wdf_rdy low");

	a_rd_rdy: assert property (@(posedge ti_clk) disable iff (!rst_n)
		app_en && !app_cmd_wr |-> app_rdy)
		else $error("read command issued while app_rdy low");

	// only returned beats reach the out fifo
	a_ob_wr: assert property (@(posedge ti_clk) disable iff (!rst_n)
		ob_wr |-> app_rd_data_valid)
		else $error("out fifo write without read data valid");

	a_calib: assert property (@(posedge ti_clk) disable iff (!rst_n)
		!(app_rdy && app_wdf_rdy) |-> !app_en) // rdy low until calibrated
		else $error("memory command issued before calibration done");

endmodule

// File: verification/ramtest_tb.sv
/*
 * testbench for the ram loopback top level
 * inputs change on the falling edge, outputs are sampled there too
 * expected words come from the record of words accepted at pipe-in
 * stops at the first mismatch or timeout
 */
`timescale 1ns/10ps

module ramtest_tb;

	localparam int TIMEOUT = 2000; // cycles per wait loop

	logic                             ti_clk;
	logic                             rst_n;
	logic                             pi_write;
	ramtest_pkg::word_t               pi_data;
	logic                             po_read;
	logic                             ctrl_write;
	logic [ramtest_pkg::CTRL_W-1:0]   ctrl_data;
	logic                             pi_full;
	ramtest_pkg::word_t               po_data;
	logic                             po_empty;
	logic [ramtest_pkg::STATUS_W-1:0] status;

	integer             seed = 78836;
	ramtest_pkg::word_t acc_q[$];     // accepted, not yet a whole beat
	ramtest_pkg::word_t exp_q[$];     // expected at pipe-out, in order
	int                 rd_target = 0; // words the reader may take
	int                 rd_done = 0;
	bit                 run_done = 0;
	bit                 fail_shown = 0;

	ramtest_top u_ramtest_top (.*);

	bind ram_traffic_ctrl ramtest_assert u_assert (
		.ti_clk(ti_clk), .rst_n(rst_n), .app_en(app_en), .app_cmd_wr(app_cmd_wr),
		.app_wdf_wren(app_wdf_wren), .app_rdy(app_rdy), .app_wdf_rdy(app_wdf_rdy),
		.app_rd_data_valid(app_rd_data_valid), .ob_wr(ob_wr));

	initial begin
		ti_clk = 1'b0;
		forever #20 ti_clk = ~ti_clk; // 40 ns period
	end

	// ------------------------------------------------------------
	// reference and compare
	function automatic int whole_beat_words(input int n_acc);
		return n_acc - (n_acc % ramtest_pkg::WORDS_PER_BEAT); // partial beat stays in packer
	endfunction

	function automatic logic [ramtest_pkg::STATUS_W-1:0] status_word(input logic calib,
		input logic full, input logic empty, input logic rd, input logic wr);
		logic [ramtest_pkg::STATUS_W-1:0] s;
		s = '0;
		s[ramtest_pkg::STAT_CALIB]    = calib;
		s[ramtest_pkg::STAT_PI_FULL]  = full;
		s[ramtest_pkg::STAT_PO_EMPTY] = empty;
		s[ramtest_pkg::STAT_RD_EN]    = rd;
		s[ramtest_pkg::STAT_WR_EN]    = wr;
		return s;
	endfunction

	task automatic stop_with_failure(input string msg);
		fail_shown = 1'b1;
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first error");
	endtask

	// pipe-out word against the reference queue
	task automatic check_word(input ramtest_pkg::word_t got, input ramtest_pkg::word_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("Fail %0t: pipe-out word %0d is %h, expected %h",
				$time, rd_done, got, exp));
	endtask

	task automatic check_status(input logic [ramtest_pkg::STATUS_W-1:0] got,
		input logic [ramtest_pkg::STATUS_W-1:0] exp, input string what);
		if (got !== exp)
			stop_with_failure($sformatf("Fail %0t: status %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	// pipe-out reader, takes a word whenever one is owed
	initial begin
		po_read = 1'b0;
		forever begin
			@(negedge ti_clk);
			po_read = 1'b0;
			if (rst_n && rd_done < rd_target && !po_empty) begin
				check_word(po_data, exp_q[rd_done]);
				po_read = 1'b1;
				rd_done++;
			end
		end
	end

	// ------------------------------------------------------------
	// host side tasks
	task automatic write_ctrl(input logic [ramtest_pkg::CTRL_W-1:0] val);
		@(negedge ti_clk);
		ctrl_write = 1'b1;
		ctrl_data  = val;
		@(negedge ti_clk);
		ctrl_write = 1'b0;
		@(negedge ti_clk); // status now shows the new enables
	endtask

	task automatic send_words(input int n);
		int sent;
		int waited;
		sent   = 0;
		waited = 0;
		while (sent < n) begin
			@(negedge ti_clk);
			pi_write = 1'b0;
			if (!pi_full) begin
				pi_data  = ramtest_pkg::word_t'($random(seed));
				pi_write = 1'b1;
				acc_q.push_back(pi_data); // taken at the next rising edge
				sent++;
				waited = 0;
			end else begin
				waited++;
				if (waited > TIMEOUT)
					stop_with_failure("timeout: pi_full stayed high while sending words");
			end
		end
		@(negedge ti_clk);
		pi_write = 1'b0;
	endtask

	task automatic fill_until_full();
		int sent;
		sent = 0;
		forever begin
			@(negedge ti_clk);
			pi_write = 1'b0;
			if (pi_full)
				break;
			pi_data  = ramtest_pkg::word_t'($random(seed));
			pi_write = 1'b1;
			acc_q.push_back(pi_data);
			sent++;
			if (sent > TIMEOUT)
				stop_with_failure("timeout: pi_full never rose with reads disabled");
		end
	endtask

	// whole beats become owed to the reader
	task automatic release_beats();
		int n;
		@(posedge ti_clk);
		n = whole_beat_words(acc_q.size());
		repeat (n) exp_q.push_back(acc_q.pop_front());
		rd_target += n;
	endtask

	task automatic drain_expected();
		int waited;
		waited = 0;
		while (rd_done != rd_target) begin
			@(posedge ti_clk);
			waited++;
			if (waited > TIMEOUT)
				stop_with_failure("timeout: expected words did not reach pipe-out");
		end
	endtask

	task automatic wait_out_data();
		int waited;
		waited = 0;
		while (po_empty) begin
			@(negedge ti_clk);
			waited++;
			if (waited > TIMEOUT)
				stop_with_failure("timeout: no beat reached pipe-out before soft reset");
		end
	endtask

	task automatic expect_idle(input int cycles, input string what);
		repeat (cycles) begin
			@(negedge ti_clk);
			if (!po_empty)
				stop_with_failure($sformatf("pipe-out offered an extra word %s", what));
		end
	endtask

	task automatic wait_calib();
		int waited;
		waited = 0;
		while (!status[ramtest_pkg::STAT_CALIB]) begin
			@(negedge ti_clk);
			waited++;
			if (waited > 4 * ramtest_pkg::CALIB_CYCLES)
				stop_with_failure("timeout waiting for memory calibration");
		end
	endtask

	// ------------------------------------------------------------
	// test sequence
	initial begin
		rst_n      = 1'b0;
		pi_write   = 1'b0;
		pi_data    = '0;
		ctrl_write = 1'b0;
		ctrl_data  = '0;
		repeat (16) @(negedge ti_clk);
		rst_n = 1'b1;

		@(negedge ti_clk);
		check_status(status, status_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b0), "after reset");
		wait_calib();
		check_status(status, status_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b0), "after calibration");

		for (int c = 0; c < 4; c++) begin // every enable pair
			write_ctrl(ramtest_pkg::CTRL_W'(c));
			check_status(status, status_word(1'b1, 1'b0, 1'b1, c[0], c[1]), "enable readback");
		end

		write_ctrl(3'b011); // loopback
		send_words(64);
		release_beats();
		drain_expected();
		expect_idle(20, "after loopback");

		write_ctrl(3'b010); // write only, data held in memory
		send_words(32);
		expect_idle(40, "with reads disabled");
		write_ctrl(3'b011);
		release_beats();
		drain_expected();
		expect_idle(20, "after held data");

		write_ctrl(3'b010);
		fill_until_full();
		@(negedge ti_clk);
		check_status(status, status_word(1'b1, 1'b1, 1'b1, 1'b0, 1'b1), "when full");
		write_ctrl(3'b011);
		release_beats();
		drain_expected();
		expect_idle(40, "beyond the accepted whole beats");

		// out fifo full, beats left in memory, partial beat in the packer
		write_ctrl(3'b011);
		send_words(51);
		wait_out_data();
		write_ctrl(3'b100);
		acc_q.delete(); // everything before the soft reset is gone
		expect_idle(10, "after soft reset");
		check_status(status, status_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b0), "after soft reset");
		write_ctrl(3'b011);
		send_words(24);
		release_beats();
		drain_expected();
		expect_idle(20, "after soft reset data");

		run_done = 1'b1;
		$display("NO ERRORS");
		$finish;
	end

	// run cut short without a report, e.g. by a bound assertion
	final begin
		if (!run_done && !fail_shown)
			$display("ERRORS FOUND");
	end

endmodule
